/* tb.f */
+incdir+verif
design/rf_pkg.sv
design/bist_pkg.sv
design/rf_core.sv
design/rf_test_wrap.sv
design/march_bist.sv
design/rf_subsys.sv
verif/rf_tb.sv

/* verif/rf_tests.svh */
`ifndef RF_TESTS_SVH
`define RF_TESTS_SVH

//////////////////////////////////////////////////////////////////////
// Stimulus helpers
//////////////////////////////////////////////////////////////////////

function automatic rf_addr_t rand_addr(input int lo, input int hi);
   return rf_addr_t'($urandom_range(hi, lo));
endfunction

function automatic rf_wr_t random_write(input rf_addr_t addr);
   rf_wr_t w;
   w.we   = 1'b1;
   w.addr = addr;
   w.data = $urandom;
   return w;
endfunction

// Two words per cycle through both ports
task automatic fill_all();
   rf_wr_t wb;
   for (int i = 1; i < RF_WORDS; i += 2)
   begin
      wb = (i + 1 < RF_WORDS) ? random_write(rf_addr_t'(i + 1)) : '0;
      run_cycle('{a: rand_addr(0, 31), b: rand_addr(0, 31), c: rand_addr(0, 31)},
                random_write(rf_addr_t'(i)), wb, 1'b0, 1'b0);
   end
endtask

//////////////////////////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////////////////////////

task automatic test_reset();
   repeat (8)
   begin
      run_cycle('{a: rand_addr(0, 31), b: rand_addr(0, 31), c: rand_addr(0, 31)},
                '0, '0, 1'b0, 1'b0);
   end
   check_res("result after reset", bist_res, '0);
endtask

task automatic test_writes();
   rf_wr_t   wa;
   rf_wr_t   wb;
   rf_addr_t addr;
   repeat (24)
   begin
      wa    = random_write(rand_addr(0, 31));
      wb    = random_write(rand_addr(0, 31));
      wa.we = 1'($urandom_range(1, 0));
      // Reading the written words in the same cycle expects the old value
      run_cycle('{a: wa.addr, b: wb.addr, c: rand_addr(0, 31)}, wa, wb, 1'b0, 1'b0);
   end
   // Both ports on one word
   addr = rand_addr(1, 31);
   wa   = random_write(addr);
   wb   = random_write(addr);
   run_cycle('{a: addr, b: addr, c: addr}, wa, wb, 1'b0, 1'b0);
   run_cycle('{a: addr, b: '0, c: addr}, random_write('0), random_write('0), 1'b0, 1'b0);
   run_cycle('{a: addr, b: '0, c: '0}, '0, '0, 1'b0, 1'b0);
   check_word("port B priority", rd_data.a, wb.data);
   check_word("zero register", rd_data.b, '0);
endtask

task automatic test_reads();
   rf_rd_addr_t ra;
   fill_all();
   repeat (20)
   begin
      ra.a = rand_addr(0, 31);
      do
      begin
         ra.b = rand_addr(0, 31);
      end
      while (ra.b == ra.a);
      do
      begin
         ra.c = rand_addr(0, 31);
      end
      while (ra.c == ra.a || ra.c == ra.b);
      run_cycle(ra, '0, '0, 1'b0, 1'b0);
   end
endtask

task automatic test_bist_run();
   int        n;
   bist_res_t exp;
   fill_all();
   run_cycle('0, '0, '0, 1'b0, 1'b1);
   wait_done(n);
   if (n != BIST_CYCLES)
      report_error($sformatf("done after %0d cycles, expected %0d", n, BIST_CYCLES));
   exp      = '0;
   exp.done = 1'b1;
   check_res("BIST result", bist_res, exp);
   // Scrambled range covers physical words 1 to 15, which end at zero
   for (int i = 1; i <= BIST_WORDS; i++)
   begin
      ref_mem[i] = '0;
   end
   for (int i = 0; i < RF_WORDS; i++)
   begin
      run_cycle('{a: rf_addr_t'(i), b: rf_addr_t'(31 - i), c: rf_addr_t'(i)},
                '0, '0, 1'b0, 1'b0);
   end
endtask

task automatic test_bist_traffic();
   int        n;
   bist_res_t exp;
   fill_all();
   run_cycle('0, '0, '0, 1'b0, 1'b1);
   // Upper words only
   // The lower half changes under the march
   for (int k = 1; k <= 40; k++)
   begin
      run_cycle('{a: rand_addr(0, 31), b: rand_addr(16, 31), c: rand_addr(16, 31)},
                random_write(rand_addr(16, 31)), random_write(rand_addr(16, 31)),
                1'b1, k == 20);
      check_res("result while busy", bist_res, '0);
   end
   wait_done(n);
   if (40 + n != BIST_CYCLES)
      report_error($sformatf("done after %0d cycles, expected %0d", 40 + n, BIST_CYCLES));
   exp      = '0;
   exp.done = 1'b1;
   check_res("BIST result", bist_res, exp);
   for (int i = 1; i <= BIST_WORDS; i++)
   begin
      ref_mem[i] = '0;
   end
   // Dropped writes leave words 16 to 31 as they were
   for (int i = 16; i < RF_WORDS; i++)
   begin
      run_cycle('{a: rf_addr_t'(i), b: rf_addr_t'(i), c: rf_addr_t'(i)}, '0, '0, 1'b0, 1'b0);
      check_res("result after BIST", bist_res, '0);
   end
   // Ignored second start gives no late done
   repeat (BIST_CYCLES)
   begin
      run_cycle('{a: rand_addr(0, 31), b: rand_addr(0, 31), c: rand_addr(0, 31)},
                '0, '0, 1'b0, 1'b0);
      check_res("result after BIST", bist_res, '0);
   end
endtask

`endif

/* verif/rf_tb.sv */
module rf_tb
   import rf_pkg::*;
   import bist_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   // Cycles from the sampled start edge to done
   // M0 and M3 take one cycle per word, M1 and M2 take two, plus FLUSH and DONE
   localparam int BIST_CYCLES = 6 * BIST_WORDS + 2;

   // Longest wait for a done strobe
   localparam int DONE_WAIT_LIMIT = 2 * BIST_CYCLES;

   // Run limit
   // Reset and the directed tests take about 450 cycles
   localparam int TIMEOUT_CYCLES = 2000;

   logic        clk;
   logic        rst_n;
   rf_rd_addr_t rd_addr;
   rf_wr_t      wr_a;
   rf_wr_t      wr_b;
   rf_rd_data_t rd_data;
   logic        bist_start;
   bist_res_t   bist_res;

   // Expected register contents
   // Word 0 stays zero
   rf_data_t    ref_mem [0:RF_WORDS-1];

   int          errors = 0;
   int          cycle_cnt = 0;

   rf_subsys uut (
      .clk          (clk),
      .rst_n        (rst_n),
      .rd_addr_i    (rd_addr),
      .wr_a_i       (wr_a),
      .wr_b_i       (wr_b),
      .rd_data_o    (rd_data),
      .bist_start_i (bist_start),
      .bist_res_o   (bist_res)
   );

   //////////////////////////////////////////////////////////////////////
   // Clock and run limit
   //////////////////////////////////////////////////////////////////////

   always #2 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checking helpers
   //////////////////////////////////////////////////////////////////////

   task automatic report_error(input string msg);
      $display("error at %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic check_word(input string what, input rf_data_t got, input rf_data_t exp);
      if (got !== exp)
         report_error($sformatf("%s read %h, expected %h", what, got, exp));
   endtask

   task automatic check_res(input string what, input bist_res_t got, input bist_res_t exp);
      if (got !== exp)
         report_error($sformatf("%s gave done %b fail %b addr %0d, expected %b %b %0d",
            what, got.done, got.fail, got.fail_addr, exp.done, exp.fail, exp.fail_addr));
   endtask

   // Zero register ignores writes
   // Port B lands last so it wins
   task automatic ref_write(input rf_wr_t w);
      if (w.we && w.addr != '0)
         ref_mem[w.addr] = w.data;
   endtask

   // One bus cycle
   // Inputs change at the rising edge
   // Reads are sampled at the falling edge before the write commits,
   // so the old word is expected
   task automatic run_cycle(input rf_rd_addr_t ra, input rf_wr_t wa, input rf_wr_t wb,
                            input bit in_bist, input logic start);
      @(posedge clk);
      rd_addr    <= ra;
      wr_a       <= wa;
      wr_b       <= wb;
      bist_start <= start;
      @(negedge clk);
      // Port A carries test data while BIST runs
      if (!in_bist)
         check_word($sformatf("port a word %0d", ra.a), rd_data.a, ref_mem[ra.a]);
      check_word($sformatf("port b word %0d", ra.b), rd_data.b, ref_mem[ra.b]);
      check_word($sformatf("port c word %0d", ra.c), rd_data.c, ref_mem[ra.c]);
      // Functional writes are dropped during BIST
      if (!in_bist)
      begin
         ref_write(wa);
         ref_write(wb);
      end
   endtask

   // Idle cycles until done
   // n counts cycles after the start cycle
   task automatic wait_done(output int n);
      logic done_seen;
      n = 0;
      done_seen = 1'b0;
      while (!done_seen && n < DONE_WAIT_LIMIT)
      begin
         run_cycle('0, '0, '0, 1'b1, 1'b0);
         n++;
         done_seen = bist_res.done;
      end
      if (!done_seen)
      begin
         $display("BIST done strobe did not arrive within %0d cycles", DONE_WAIT_LIMIT);
         errors++;
      end
   endtask

   `include "rf_tests.svh"

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      void'($urandom(32'h507));
      clk        = 1'b0;
      rst_n      = 1'b0;
      rd_addr    = '0;
      wr_a       = '0;
      wr_b       = '0;
      bist_start = 1'b0;
      for (int i = 0; i < RF_WORDS; i++)
      begin
         ref_mem[i] = '0;
      end
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      test_reset();
      test_writes();
      test_reads();
      test_bist_run();
      test_bist_traffic();

      $display("Run complete after %0d cycles, %0d errors", cycle_cnt, errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

/* design/rf_subsys.sv */
module rf_subsys
   import rf_pkg::*;
   import bist_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,

   // Functional register file ports
   input  rf_rd_addr_t rd_addr_i,
   input  rf_wr_t      wr_a_i,
   input  rf_wr_t      wr_b_i,
   output rf_rd_data_t rd_data_o,

   // Self test control
   input  logic        bist_start_i,
   output bist_res_t   bist_res_o
);

   //////////////////////////////////////////////////////////////////////
   // Internal wiring
   //////////////////////////////////////////////////////////////////////

   // Engine to wrapper
   logic        bist_mode;
   bist_req_t   bist_req;
   rf_data_t    q_t;

   // Wrapper to core
   rf_rd_addr_t rd_addr;
   rf_wr_t      wr_a;
   rf_wr_t      wr_b;
   rf_rd_data_t rd_data;

   march_bist u_march_bist (
      .clk         (clk),
      .rst_n       (rst_n),
      .start_i     (bist_start_i),
      .q_t_i       (q_t),
      .bist_mode_o (bist_mode),
      .bist_req_o  (bist_req),
      .res_o       (bist_res_o)
   );

   rf_test_wrap u_rf_test_wrap (
      .clk            (clk),
      .rst_n          (rst_n),
      .bist_mode_i    (bist_mode),
      .bist_req_i     (bist_req),
      .q_t_o          (q_t),
      .rd_addr_i      (rd_addr_i),
      .wr_a_i         (wr_a_i),
      .wr_b_i         (wr_b_i),
      .rd_data_o      (rd_data_o),
      .core_rd_addr_o (rd_addr),
      .core_wr_a_o    (wr_a),
      .core_wr_b_o    (wr_b),
      .core_rd_data_i (rd_data)
   );

   rf_core u_rf_core (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data),
      .wr_a_i    (wr_a),
      .wr_b_i    (wr_b)
   );

endmodule

/* design/march_bist.sv */
module march_bist
   import rf_pkg::*;
   import bist_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,

   // Single cycle start strobe
   input  logic      start_i,

   // Read data of the request issued one cycle earlier
   input  rf_data_t  q_t_i,

   output logic      bist_mode_o,
   output bist_req_t bist_req_o,
   output bist_res_t res_o
);

   // Highest logical address visited
   localparam rf_addr_t LAST_ADDR = rf_addr_t'(BIST_WORDS - 1);

   march_elem_t state_q;
   march_elem_t state_d;
   rf_addr_t    addr_q;
   rf_addr_t    addr_d;
   logic        phase_q;
   logic        phase_d;
   logic        go;

   // Read issue and the word it should return
   logic        rd_issue;
   rf_data_t    rd_exp;

   // Check of the read in flight
   logic        chk_vld_q;
   rf_data_t    chk_exp_q;
   rf_addr_t    chk_addr_q;
   logic        mismatch;

   logic        fail_q;
   rf_addr_t    fail_addr_q;

   // Start only counts in IDLE
   assign go = (state_q == IDLE) && start_i;

   //////////////////////////////////////////////////////////////////////
   // Element sequencing
   //////////////////////////////////////////////////////////////////////

   // Phase 0 is the read and phase 1 the write inside M1 and M2
   always_comb
   begin
      state_d = state_q;
      addr_d  = addr_q;
      phase_d = phase_q;
      case (state_q)
         IDLE:
         begin
            if (go)
            begin
               state_d = M0_W0;
               addr_d  = '0;
               phase_d = 1'b0;
            end
         end
         M0_W0:
         begin
            if (addr_q == LAST_ADDR)
               state_d = M1_R0W1;
            addr_d = (addr_q == LAST_ADDR) ? '0 : addr_q + rf_addr_t'(1);
         end
         M1_R0W1:
         begin
            phase_d = !phase_q;
            if (phase_q)
            begin
               if (addr_q == LAST_ADDR)
                  state_d = M2_R1W0;
               // M2 starts from the top
               addr_d = (addr_q == LAST_ADDR) ? LAST_ADDR : addr_q + rf_addr_t'(1);
            end
         end
         M2_R1W0:
         begin
            phase_d = !phase_q;
            if (phase_q)
            begin
               if (addr_q == '0)
                  state_d = M3_R0;
               addr_d = (addr_q == '0) ? LAST_ADDR : addr_q - rf_addr_t'(1);
            end
         end
         M3_R0:
         begin
            if (addr_q == '0)
               state_d = FLUSH;
            else
               addr_d = addr_q - rf_addr_t'(1);
         end
         // Last read gets checked here
         FLUSH:   state_d = DONE;
         DONE:    state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= IDLE;
         addr_q  <= '0;
         phase_q <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         addr_q  <= addr_d;
         phase_q <= phase_d;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Request generation
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      bist_req_o.csn  = 1'b1;
      bist_req_o.wen  = 1'b1;
      bist_req_o.addr = addr_q;
      bist_req_o.data = '0;
      rd_issue        = 1'b0;
      rd_exp          = '0;
      case (state_q)
         M0_W0:
         begin
            bist_req_o.csn = 1'b0;
            bist_req_o.wen = 1'b0;
         end
         M1_R0W1:
         begin
            // Read 0 then write all ones
            bist_req_o.csn  = 1'b0;
            bist_req_o.wen  = !phase_q;
            bist_req_o.data = '1;
            rd_issue        = !phase_q;
         end
         M2_R1W0:
         begin
            // Read all ones then write 0
            bist_req_o.csn = 1'b0;
            bist_req_o.wen = !phase_q;
            rd_issue       = !phase_q;
            rd_exp         = '1;
         end
         M3_R0:
         begin
            bist_req_o.csn = 1'b0;
            rd_issue       = 1'b1;
         end
         default:
         begin
            rd_issue = 1'b0;
         end
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Read checking
   //////////////////////////////////////////////////////////////////////

   // Expected word and address of the read in flight
   always_ff @(posedge clk)
   begin
      if (rd_issue)
      begin
         chk_exp_q  <= rd_exp;
         chk_addr_q <= addr_q;
      end
   end

   assign mismatch = chk_vld_q && (q_t_i != chk_exp_q);

   // Only the first failing address is kept
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         chk_vld_q   <= 1'b0;
         fail_q      <= 1'b0;
         fail_addr_q <= '0;
      end
      else
      begin
         chk_vld_q <= rd_issue;
         if (go)
         begin
            fail_q      <= 1'b0;
            fail_addr_q <= '0;
         end
         else if (mismatch && !fail_q)
         begin
            fail_q      <= 1'b1;
            fail_addr_q <= chk_addr_q;
         end
      end
   end

   // Test mode covers the march and the flush, and drops with done
   assign bist_mode_o     = (state_q != IDLE) && (state_q != DONE);
   assign res_o.done      = (state_q == DONE);
   assign res_o.fail      = fail_q;
   assign res_o.fail_addr = fail_addr_q;

   a_done_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      res_o.done |=> !res_o.done);

endmodule

/* design/rf_test_wrap.sv */
module rf_test_wrap
   import rf_pkg::*;
   import bist_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,

   // Test collar side
   input  logic        bist_mode_i,
   input  bist_req_t   bist_req_i,
   output rf_data_t    q_t_o,

   // Functional side
   input  rf_rd_addr_t rd_addr_i,
   input  rf_wr_t      wr_a_i,
   input  rf_wr_t      wr_b_i,
   output rf_rd_data_t rd_data_o,

   // Toward the register file
   output rf_rd_addr_t core_rd_addr_o,
   output rf_wr_t      core_wr_a_o,
   output rf_wr_t      core_wr_b_o,
   input  rf_rd_data_t core_rd_data_i
);

   logic     tst_wr;
   logic     tst_rd;
   rf_addr_t tst_addr;
   rf_addr_t tst_rd_addr_q;

   // Request decode from the active low collar strobes
   assign tst_wr = !bist_req_i.csn && !bist_req_i.wen;
   assign tst_rd = !bist_req_i.csn &&  bist_req_i.wen;

   // Collar scrambling
   // MSB dropped and remaining bits inverted, so only words 1 to 15 are reachable
   assign tst_addr = {1'b0, ~bist_req_i.addr[RF_ADDR_W-2:0]};

   //////////////////////////////////////////////////////////////////////
   // Test read address register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         tst_rd_addr_q <= '0;
      end
      else if (tst_rd)
      begin
         tst_rd_addr_q <= tst_addr;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Port multiplexing
   //////////////////////////////////////////////////////////////////////

   // Port A carries the test write in BIST mode
   assign core_wr_a_o.we   = bist_mode_i ? tst_wr          : wr_a_i.we;
   assign core_wr_a_o.addr = bist_mode_i ? tst_addr        : wr_a_i.addr;
   assign core_wr_a_o.data = bist_mode_i ? bist_req_i.data : wr_a_i.data;

   // Port B is masked for the whole test
   assign core_wr_b_o = bist_mode_i ? '0 : wr_b_i;

   // Read port A follows the registered test address
   assign core_rd_addr_o.a = bist_mode_i ? tst_rd_addr_q : rd_addr_i.a;
   assign core_rd_addr_o.b = rd_addr_i.b;
   assign core_rd_addr_o.c = rd_addr_i.c;

   // Test read data comes back on port A
   assign q_t_o     = core_rd_data_i.a;
   assign rd_data_o = core_rd_data_i;

   a_port_b_masked: assert property (@(posedge clk) disable iff (!rst_n)
      bist_mode_i |-> !core_wr_b_o.we);

   // Engine address range keeps test writes off the zero register
   a_no_zero_wr: assert property (@(posedge clk) disable iff (!rst_n)
      (bist_mode_i && core_wr_a_o.we) |-> (core_wr_a_o.addr != '0));

endmodule

/* design/rf_core.sv */
module rf_core
   import rf_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,

   // Read side
   input  rf_rd_addr_t rd_addr_i,
   output rf_rd_data_t rd_data_o,

   // Write side
   input  rf_wr_t      wr_a_i,
   input  rf_wr_t      wr_b_i
);

   // Storage for words 1 to 31
   rf_data_t mem_q [1:RF_WORDS-1];

   // Full view with the zero register in front
   rf_data_t words [0:RF_WORDS-1];

   // One hot write strobes per word
   logic [RF_WORDS-1:1] we_a_dec;
   logic [RF_WORDS-1:1] we_b_dec;

   //////////////////////////////////////////////////////////////////////
   // Write decode
   //////////////////////////////////////////////////////////////////////

   // Address 0 has no strobe at all
   always_comb
   begin
      for (int i = 1; i < RF_WORDS; i++)
      begin
         we_a_dec[i] = wr_a_i.we && (wr_a_i.addr == rf_addr_t'(i));
         we_b_dec[i] = wr_b_i.we && (wr_b_i.addr == rf_addr_t'(i));
      end
   end

   // Port B takes the word when both ports hit it
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 1; i < RF_WORDS; i++)
         begin
            mem_q[i] <= '0;
         end
      end
      else
      begin
         for (int i = 1; i < RF_WORDS; i++)
         begin
            if (we_b_dec[i])
               mem_q[i] <= wr_b_i.data;
            else if (we_a_dec[i])
               mem_q[i] <= wr_a_i.data;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read multiplexers
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      words[0] = '0;
      for (int i = 1; i < RF_WORDS; i++)
      begin
         words[i] = mem_q[i];
      end
   end

   // Combinational, so a same cycle write shows up one cycle later
   assign rd_data_o.a = words[rd_addr_i.a];
   assign rd_data_o.b = words[rd_addr_i.b];
   assign rd_data_o.c = words[rd_addr_i.c];

   // Zero register stays zero after any write aimed at it
   a_zero_reg: assert property (@(posedge clk) disable iff (!rst_n)
      ((wr_a_i.we && wr_a_i.addr == '0) || (wr_b_i.we && wr_b_i.addr == '0))
      |=> ((rd_addr_i.a != '0 || rd_data_o.a == '0) &&
           (rd_addr_i.b != '0 || rd_data_o.b == '0) &&
           (rd_addr_i.c != '0 || rd_data_o.c == '0)));

endmodule

/* design/bist_pkg.sv */
package bist_pkg;

   import rf_pkg::*;

   //////////////////////////////////////////////////////////////////////
   // Test coverage
   //////////////////////////////////////////////////////////////////////

   // Logical words 0 to 14
   // Logical 15 would scramble onto the zero register
   localparam int BIST_WORDS = 15;

   //////////////////////////////////////////////////////////////////////
   // Collar request and engine result
   //////////////////////////////////////////////////////////////////////

   // Memory style request, select and write enable are active low
   typedef struct packed {
      logic     csn;
      logic     wen;
      rf_addr_t addr;
      rf_data_t data;
   } bist_req_t;

   // Done is a one cycle strobe
   // Fail stays set until the next start
   typedef struct packed {
      logic     done;
      logic     fail;
      rf_addr_t fail_addr;
   } bist_res_t;

   // March C- elements plus bookkeeping states
   typedef enum logic [2:0] {
      IDLE,
      M0_W0,
      M1_R0W1,
      M2_R1W0,
      M3_R0,
      FLUSH,
      DONE
   } march_elem_t;

endpackage

/* design/rf_pkg.sv */
package rf_pkg;

   //////////////////////////////////////////////////////////////////////
   // Register file geometry
   //////////////////////////////////////////////////////////////////////

   // Five address bits select one of 32 words
   localparam int RF_ADDR_W = 5;

   // Architectural word width
   localparam int RF_DATA_W = 32;

   // Word count including the hardwired zero register
   localparam int RF_WORDS  = 32;

   typedef logic [RF_ADDR_W-1:0] rf_addr_t;
   typedef logic [RF_DATA_W-1:0] rf_data_t;

   //////////////////////////////////////////////////////////////////////
   // Port bundles
   //////////////////////////////////////////////////////////////////////

   // One write port
   typedef struct packed {
      logic     we;
      rf_addr_t addr;
      rf_data_t data;
   } rf_wr_t;

   // Addresses of the three read ports
   typedef struct packed {
      rf_addr_t a;
      rf_addr_t b;
      rf_addr_t c;
   } rf_rd_addr_t;

   // Words returned on the three read ports
   typedef struct packed {
      rf_data_t a;
      rf_data_t b;
      rf_data_t c;
   } rf_rd_data_t;

endpackage
